/* vlog.f */
+incdir+.
ethFramePkg.sv
ethStatusPkg.sv
ethCrc32.sv
ethAddrFilter.sv
ethFrameStatus.sv
ethRxCheck.sv
tb_ethRxCheck.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_ethRxCheck \
  -f vlog.f \
  -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "sim passed" "$logFile"; then
  exit 0
fi
echo "pass line not found in $logFile"
exit 1

/* tb_ethRxCheck.sv */
`timescale 1ns/1ps

`include "eth_defines.svh"

module tb_ethRxCheck;

  import ethFramePkg::*;
  import ethStatusPkg::*;

  localparam macAddrT srcAddr   = 48'h02_00_00_00_00_01;
  localparam macAddrT otherAddr = 48'h02_1a_3c_55_e7_0a;
  localparam int totalBytes = 862;  // every byte the tests below send

  logic       clk = 1'b0;
  logic       reset;
  byteT       dataIn;
  logic       dataValid;
  logic       startOfPacket;
  logic       endOfPacket;
  logic       sync;
  macAddrT    stationAddr;
  logic       frameGood;
  logic       frameBad;
  dropReasonT dropReason;
  frameCountT goodCount;
  frameCountT badCount;
  crcT        crcValue;

  byteT        frameBuf [0:2047];
  int          frameLen;
  crcT         frameFcs;
  logic        fcsCheck;
  logic [31:0] lfsr = 32'h0101_7e1d;

  // expected verdicts with the oldest at rdPtr
  logic       expGoodArr   [0:63];
  dropReasonT expReasonArr [0:63];
  int         expCycleArr  [0:63];
  int         rdPtr = 0;
  int         wrPtr = 0;
  int         cycleCount = 0;
  int         errorCount = 0;
  frameCountT tallyGood = '0;
  frameCountT tallyBad = '0;
  logic       headValid;
  logic       headGood;
  dropReasonT headReason;
  int         headCycle;
  frameCountT nextGood;
  frameCountT nextBad;

  ethRxCheck u_ethRxCheck (
    .clk           (clk),
    .reset         (reset),
    .dataIn        (dataIn),
    .dataValid     (dataValid),
    .startOfPacket (startOfPacket),
    .endOfPacket   (endOfPacket),
    .sync          (sync),
    .stationAddr   (stationAddr),
    .frameGood     (frameGood),
    .frameBad      (frameBad),
    .dropReason    (dropReason),
    .goodCount     (goodCount),
    .badCount      (badCount),
    .crcValue      (crcValue)
  );

  always #20 clk = ~clk;

  assign headValid  = rdPtr != wrPtr;
  assign headGood   = expGoodArr[rdPtr[5:0]];
  assign headReason = expReasonArr[rdPtr[5:0]];
  assign headCycle  = expCycleArr[rdPtr[5:0]];
  assign nextGood   = tallyGood + frameCountT'(headGood);
  assign nextBad    = tallyBad + frameCountT'(!headGood);

  // retire the head on its verdict, or once its cycle has passed without one
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (headValid && (frameGood || frameBad || cycleCount > headCycle))
    begin
      rdPtr <= rdPtr + 1;
      if (frameGood || frameBad)
      begin
        tallyGood <= nextGood;
        tallyBad  <= nextBad;
      end
    end
  end

  a_verdictExpected: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) |-> headValid)
    else
    begin
      $display("unexpected verdict at %0t with no frame pending", $time);
      errorCount++;
    end

  a_verdictOnTime: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> cycleCount == headCycle)
    else
    begin
      $display("mismatch at %0t: verdict cycle expected %0d got %0d", $time,
               $sampled(headCycle), $sampled(cycleCount));
      errorCount++;
    end

  a_goodMatch: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> frameGood == headGood)
    else
    begin
      $display("mismatch at %0t: frameGood expected %0b got %0b", $time,
               $sampled(headGood), $sampled(frameGood));
      errorCount++;
    end

  a_badMatch: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> frameBad == !headGood)
    else
    begin
      $display("mismatch at %0t: frameBad expected %0b got %0b", $time,
               !$sampled(headGood), $sampled(frameBad));
      errorCount++;
    end

  a_reasonMatch: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> dropReason == headReason)
    else
    begin
      $display("mismatch at %0t: dropReason expected %0d got %0d", $time,
               $sampled(headReason), $sampled(dropReason));
      errorCount++;
    end

  a_goodCount: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> goodCount == nextGood)
    else
    begin
      $display("mismatch at %0t: goodCount expected %0d got %0d", $time,
               $sampled(nextGood), $sampled(goodCount));
      errorCount++;
    end

  a_badCount: assert property (@(posedge clk) disable iff (reset)
    (frameGood || frameBad) && headValid |-> badCount == nextBad)
    else
    begin
      $display("mismatch at %0t: badCount expected %0d got %0d", $time,
               $sampled(nextBad), $sampled(badCount));
      errorCount++;
    end

  a_noMissed: assert property (@(posedge clk) disable iff (reset)
    headValid |-> cycleCount <= headCycle)
    else
    begin
      $display("verdict for cycle %0d never arrived, seen at %0t", $sampled(headCycle), $time);
      errorCount++;
    end

  a_fcsValue: assert property (@(posedge clk) disable iff (reset)
    fcsCheck |-> crcValue == frameFcs)
    else
    begin
      $display("mismatch at %0t: crcValue expected %h got %h", $time,
               $sampled(frameFcs), $sampled(crcValue));
      errorCount++;
    end

  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr  = lfsrNext(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // reflected form shifting right against 0xEDB88320
  function automatic crcT fcsOf(input int count);
    crcT c;
    c = `ETH_CRC_INIT;
    for (int i = 0; i < count; i++)
    begin
      c = c ^ {24'h0, frameBuf[i]};
      for (int j = 0; j < 8; j++)
      begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic buildFrame(input macAddrT dest, input int len, input int flipAt);
    logic [31:0] bits;
    frameLen = len;
    for (int i = 0; i < 6; i++)
    begin
      frameBuf[i]     = dest[47 - 8 * i -: 8];
      frameBuf[6 + i] = srcAddr[47 - 8 * i -: 8];
    end
    for (int i = 12; i < len - 4; i++)
    begin
      takeBits(8, bits);
      frameBuf[i] = bits[7:0];
    end
    frameFcs = fcsOf(len - 4);
    for (int i = 0; i < 4; i++)
    begin
      frameBuf[len - 4 + i] = frameFcs[8 * i +: 8];  // FCS goes out low byte first
    end
    if (flipAt >= 0)
      frameBuf[flipAt] = ~frameBuf[flipAt];
  endtask

  task automatic driveByte(input byteT value, input logic first, input logic last);
    @(posedge clk);
    #2;
    dataIn        = value;
    dataValid     = 1'b1;
    startOfPacket = first;
    endOfPacket   = last;
    sync          = 1'b0;
    fcsCheck      = 1'b0;
  endtask

  task automatic driveIdle();
    @(posedge clk);
    #2;
    dataIn        = '0;
    dataValid     = 1'b0;
    startOfPacket = 1'b0;
    endOfPacket   = 1'b0;
    sync          = 1'b0;
    fcsCheck      = 1'b0;
  endtask

  task automatic pushExpect(input logic good, input dropReasonT reason, input int atCycle);
    expGoodArr[wrPtr[5:0]]   = good;
    expReasonArr[wrPtr[5:0]] = reason;
    expCycleArr[wrPtr[5:0]]  = atCycle;
    wrPtr = wrPtr + 1;
  endtask

  task automatic sendFrame(input logic gaps, input logic checkFcs, input logic good,
                           input dropReasonT reason);
    logic [31:0] r;
    for (int i = 0; i < frameLen; i++)
    begin
      if (gaps)
      begin
        takeBits(2, r);
        if (r[1:0] == 2'b00)
          driveIdle();
      end
      if (checkFcs && i == frameLen - 4)
      begin
        driveIdle();
        fcsCheck = 1'b1;  // payload is in but the FCS is not
      end
      driveByte(frameBuf[i], i == 0, i == frameLen - 1);
    end
    pushExpect(good, reason, cycleCount + 2);
  endtask

  task automatic abortAfter(input int count);
    for (int i = 0; i < count; i++)
      driveByte(frameBuf[i], i == 0, 1'b0);
    driveIdle();
    sync = 1'b1;
    pushExpect(1'b0, reasonAbort, cycleCount + 1);
    driveIdle();
  endtask

  task automatic waitVerdicts();
    while (headValid)
      driveIdle();
  endtask

  initial
  begin
    #((2 * totalBytes + 200) * 40);
    $display("watchdog expired, run still going at %0t", $time);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    reset         = 1'b1;
    dataIn        = '0;
    dataValid     = 1'b0;
    startOfPacket = 1'b0;
    endOfPacket   = 1'b0;
    sync          = 1'b0;
    fcsCheck      = 1'b0;
    frameFcs      = '0;
    stationAddr   = 48'h02_1a_3c_55_e7_09;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    driveIdle();

    buildFrame(stationAddr, 64, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    driveIdle();
    waitVerdicts();

    buildFrame(stationAddr, 64, 30);  // payload byte corrupted after the FCS
    sendFrame(1'b0, 1'b0, 1'b0, reasonCrc);
    driveIdle();
    buildFrame(`ETH_BCAST, 64, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    driveIdle();
    waitVerdicts();

    buildFrame(otherAddr, 64, -1);
    sendFrame(1'b0, 1'b0, 1'b0, reasonAddr);
    driveIdle();
    buildFrame(stationAddr, 40, -1);
    sendFrame(1'b0, 1'b0, 1'b0, reasonLength);
    driveIdle();
    waitVerdicts();

    // gapped frames and then the same mix back to back
    buildFrame(stationAddr, 64, -1);
    sendFrame(1'b1, 1'b1, 1'b1, reasonNone);
    buildFrame(`ETH_BCAST, 72, -1);
    sendFrame(1'b1, 1'b1, 1'b1, reasonNone);
    buildFrame(stationAddr, 100, -1);
    sendFrame(1'b1, 1'b1, 1'b1, reasonNone);
    driveIdle();
    buildFrame(stationAddr, 64, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    buildFrame(`ETH_BCAST, 72, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    buildFrame(stationAddr, 100, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    driveIdle();
    waitVerdicts();

    buildFrame(stationAddr, 64, -1);
    abortAfter(30);
    buildFrame(stationAddr, 64, -1);
    sendFrame(1'b0, 1'b0, 1'b1, reasonNone);
    driveIdle();
    waitVerdicts();
    repeat (4) driveIdle();

    $display("checks failed: %0d, verdicts expected: %0d", errorCount, wrPtr);
    if (errorCount == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* ethRxCheck.sv */
`timescale 1ns/1ps

module ethRxCheck (
  input  logic                     clk,
  input  logic                     reset,
  input  ethFramePkg::byteT        dataIn,
  input  logic                     dataValid,
  input  logic                     startOfPacket,
  input  logic                     endOfPacket,
  input  logic                     sync,
  input  ethFramePkg::macAddrT     stationAddr,
  output logic                     frameGood,
  output logic                     frameBad,
  output ethStatusPkg::dropReasonT dropReason,
  output ethStatusPkg::frameCountT goodCount,
  output ethStatusPkg::frameCountT badCount,
  output ethFramePkg::crcT         crcValue
);

  logic crcDone;
  logic crcErr;
  logic filterDone;
  logic addrMiss;
  logic lenErr;

  ethCrc32 u_ethCrc32 (
    .clk           (clk),
    .reset         (reset),
    .dataIn        (dataIn),
    .dataValid     (dataValid),
    .startOfPacket (startOfPacket),
    .endOfPacket   (endOfPacket),
    .sync          (sync),
    .crcValue      (crcValue),
    .crcDone       (crcDone),
    .crcErr        (crcErr)
  );

  ethAddrFilter u_ethAddrFilter (
    .clk           (clk),
    .reset         (reset),
    .dataIn        (dataIn),
    .dataValid     (dataValid),
    .startOfPacket (startOfPacket),
    .endOfPacket   (endOfPacket),
    .sync          (sync),
    .stationAddr   (stationAddr),
    .filterDone    (filterDone),
    .addrMiss      (addrMiss),
    .lenErr        (lenErr)
  );

  ethFrameStatus u_ethFrameStatus (
    .clk           (clk),
    .reset         (reset),
    .startOfPacket (startOfPacket),
    .dataValid     (dataValid),
    .sync          (sync),
    .crcDone       (crcDone),
    .crcErr        (crcErr),
    .filterDone    (filterDone),
    .addrMiss      (addrMiss),
    .lenErr        (lenErr),
    .frameGood     (frameGood),
    .frameBad      (frameBad),
    .dropReason    (dropReason),
    .goodCount     (goodCount),
    .badCount      (badCount)
  );

endmodule

/* ethFrameStatus.sv */
`timescale 1ns/1ps

module ethFrameStatus (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     startOfPacket,
  input  logic                     dataValid,
  input  logic                     sync,
  input  logic                     crcDone,
  input  logic                     crcErr,
  input  logic                     filterDone,
  input  logic                     addrMiss,
  input  logic                     lenErr,
  output logic                     frameGood,
  output logic                     frameBad,
  output ethStatusPkg::dropReasonT dropReason,
  output ethStatusPkg::frameCountT goodCount,
  output ethStatusPkg::frameCountT badCount
);

  import ethStatusPkg::*;

  statusStateT state;
  statusStateT stateNext;
  dropReasonT  failReason;
  logic        startByte;
  logic        frameOpen;
  logic        abortNow;

  function automatic frameCountT satInc(frameCountT count);
    return (count == '1) ? count : count + 1'b1;
  endfunction

  assign startByte = dataValid && startOfPacket && !sync;  // sync wins over a start byte
  // the done pulse closes the frame even though the state lags a cycle
  assign frameOpen = (state == stInFrame) && !crcDone;
  assign abortNow  = frameOpen && (sync || (dataValid && startOfPacket));

  // length first, a short frame makes the other checks meaningless
  always_comb
  begin
    if (lenErr)
      failReason = reasonLength;
    else if (crcErr)
      failReason = reasonCrc;
    else if (addrMiss)
      failReason = reasonAddr;
    else
      failReason = reasonNone;
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle, stReport:
        stateNext = startByte ? stInFrame : stIdle;
      stInFrame:
      begin
        if (startByte)
          stateNext = stInFrame;  // next frame, back to back or restarting
        else if (sync || crcDone)
          stateNext = stReport;
      end
      default:
        stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= stIdle;
      frameGood  <= 1'b0;
      frameBad   <= 1'b0;
      dropReason <= reasonNone;
      goodCount  <= '0;
      badCount   <= '0;
    end
    else
    begin
      state      <= stateNext;
      frameGood  <= 1'b0;
      frameBad   <= 1'b0;
      dropReason <= reasonNone;
      if (abortNow)
      begin
        frameBad   <= 1'b1;
        dropReason <= reasonAbort;
        badCount   <= satInc(badCount);
      end
      else if (crcDone)
      begin
        frameGood  <= failReason == reasonNone;
        frameBad   <= failReason != reasonNone;
        dropReason <= failReason;
        if (failReason == reasonNone)
          goodCount <= satInc(goodCount);
        else
          badCount <= satInc(badCount);
      end
    end
  end

  // both checkers see the same end byte, so their verdicts line up
  a_doneAligned: assert property (@(posedge clk) disable iff (reset)
    crcDone == filterDone)
    else $error("crcDone and filterDone out of step");

  a_oneVerdict: assert property (@(posedge clk) disable iff (reset)
    !(frameGood && frameBad))
    else $error("frameGood and frameBad high together");

endmodule

/* ethAddrFilter.sv */
`timescale 1ns/1ps

`include "eth_defines.svh"

module ethAddrFilter (
  input  logic                 clk,
  input  logic                 reset,
  input  ethFramePkg::byteT    dataIn,
  input  logic                 dataValid,
  input  logic                 startOfPacket,
  input  logic                 endOfPacket,
  input  logic                 sync,
  input  ethFramePkg::macAddrT stationAddr,
  output logic                 filterDone,
  output logic                 addrMiss,
  output logic                 lenErr
);

  import ethFramePkg::*;

  localparam macAddrT  bcastAddr  = `ETH_BCAST;
  localparam frameLenT minLen     = `ETH_MIN_LEN;
  localparam frameLenT maxLen     = `ETH_MAX_LEN;
  localparam frameLenT addrLen    = 11'd6;

  frameLenT byteCount;  // bytes taken so far in the open frame
  frameLenT lenNext;    // count including the current byte
  macAddrT  destAddr;
  logic     inAddr;

  always_comb
  begin
    if (startOfPacket)
    begin
      lenNext = frameLenT'(1);
    end
    else if (byteCount == '1)
    begin
      lenNext = byteCount;  // hold at the top, overlong frames fail anyway
    end
    else
    begin
      lenNext = frameLenT'(byteCount + 1'b1);
    end
  end

  assign inAddr = startOfPacket || (byteCount < addrLen);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      byteCount  <= '0;
      filterDone <= 1'b0;
    end
    else
    begin
      filterDone <= dataValid && endOfPacket && !sync;
      if (sync)
      begin
        byteCount <= '0;
      end
      else if (dataValid)
      begin
        byteCount <= endOfPacket ? '0 : lenNext;
      end
    end
  end

  // destination shifts in MSB first, complete after byte six
  always_ff @(posedge clk)
  begin
    if (dataValid && inAddr)
    begin
      destAddr <= {destAddr[39:0], dataIn};
    end
    if (dataValid && endOfPacket)
    begin
      addrMiss <= (destAddr != stationAddr) && (destAddr != bcastAddr);
      lenErr   <= (lenNext < minLen) || (lenNext > maxLen);
    end
  end

  a_noWrap: assert property (@(posedge clk) disable iff (reset)
    (byteCount == '1) && !sync && !(dataValid && (startOfPacket || endOfPacket))
    |=> byteCount == '1)
    else $error("frame length counter wrapped");

endmodule

/* ethCrc32.sv */
`timescale 1ns/1ps

`include "eth_defines.svh"

module ethCrc32 (
  input  logic              clk,
  input  logic              reset,
  input  ethFramePkg::byteT dataIn,
  input  logic              dataValid,
  input  logic              startOfPacket,
  input  logic              endOfPacket,
  input  logic              sync,
  output ethFramePkg::crcT  crcValue,
  output logic              crcDone,
  output logic              crcErr
);

  import ethFramePkg::*;

  localparam crcT crcPoly    = 32'h04C1_1DB7;
  localparam crcT crcInit    = `ETH_CRC_INIT;
  localparam crcT crcResidue = `ETH_CRC_RESIDUE;

  crcT crcReg;
  crcT crcStep;   // register after the current byte
  crcT crcBase;   // register the current byte is folded into

  // eight serial steps unrolled into one byte-wide update
  // 802.3 sends bit 0 of each byte first
  function automatic crcT nextCrc(crcT crc, byteT data);
    crcT  c;
    logic feedback;
    c = crc;
    for (int i = 0; i < 8; i++)
    begin
      feedback = c[31] ^ data[i];
      c = {c[30:0], 1'b0};
      if (feedback)
      begin
        c = c ^ crcPoly;
      end
    end
    return c;
  endfunction

  function automatic crcT reverseBits(crcT value);
    crcT r;
    for (int i = 0; i < 32; i++)
    begin
      r[i] = value[31 - i];
    end
    return r;
  endfunction

  // a start byte always folds into a fresh preset, even inside a frame
  assign crcBase = startOfPacket ? crcInit : crcReg;
  assign crcStep = nextCrc(crcBase, dataIn);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      crcReg  <= crcInit;
      crcDone <= 1'b0;
    end
    else
    begin
      crcDone <= dataValid && endOfPacket && !sync;
      if (sync)
      begin
        crcReg <= crcInit;  // abort drops whatever was in flight
      end
      else if (dataValid)
      begin
        crcReg <= crcStep;
      end
    end
  end

  // only looked at alongside crcDone
  always_ff @(posedge clk)
  begin
    if (dataValid && endOfPacket)
    begin
      crcErr <= crcStep != crcResidue;
    end
  end

  // same bit order and polarity as the FCS a transmitter appends
  assign crcValue = ~reverseBits(crcReg);

  a_eopQualified: assert property (@(posedge clk) disable iff (reset)
    endOfPacket |-> dataValid)
    else $error("endOfPacket seen without dataValid");

endmodule

/* ethStatusPkg.sv */
package ethStatusPkg;

  // why a frame was dropped, listed in no particular priority
  typedef enum logic [2:0] {
    reasonNone   = 3'd0,
    reasonCrc    = 3'd1,
    reasonAddr   = 3'd2,
    reasonLength = 3'd3,
    reasonAbort  = 3'd4
  } dropReasonT;

  typedef enum logic [1:0] {
    stIdle    = 2'd0,
    stInFrame = 2'd1,
    stReport  = 2'd2  // verdict leaves this cycle
  } statusStateT;

  typedef logic [15:0] frameCountT;  // good and bad frame tallies

endpackage

/* ethFramePkg.sv */
package ethFramePkg;

  // one byte off the receive stream
  typedef logic [7:0] byteT;

  // CRC register, or a finished CRC value
  typedef logic [31:0] crcT;

  // station or destination address, first byte on the wire in bits 47:40
  typedef logic [47:0] macAddrT;

  typedef logic [10:0] frameLenT;  // byte count, reaches 2047 before it saturates

endpackage

/* eth_defines.svh */
`ifndef ETH_DEFINES_SVH
`define ETH_DEFINES_SVH

// legal frame size in bytes, destination address through FCS
`define ETH_MIN_LEN 64
`define ETH_MAX_LEN 1518

// CRC-32 register preset, all ones per 802.3
`define ETH_CRC_INIT 32'hFFFF_FFFF

// raw register value left behind once a good frame and its FCS went through
`define ETH_CRC_RESIDUE 32'hC704_DD7B

`define ETH_BCAST 48'hFFFF_FFFF_FFFF  // broadcast destination

`endif
